// File: hw/fu_consts.svh
`ifndef FU_CONSTS_SVH
`define FU_CONSTS_SVH

`define ROB_IDX_W	5
`define PRF_IDX_W	6
`define ZERO_REG	(`PRF_IDX_W'(63))	// tag parked on an idle bus.
`define MULT_STAGES	4

`define OP_INTA		6'h10	// integer arithmetic.
`define OP_INTL		6'h11	// integer logical.
`define OP_INTS		6'h12	// shifts.
`define OP_INTM		6'h13	// integer multiply.

`define OP_BR		6'h30
`define OP_BEQ		6'h39
`define OP_BNE		6'h3d
`define OP_BLT		6'h3a
`define OP_BGE		6'h3e

`define FN_ADDQ		7'h20
`define FN_SUBQ		7'h29
`define FN_CMPEQ	7'h2d
`define FN_CMPULT	7'h1d
`define FN_AND		7'h00
`define FN_BIS		7'h20
`define FN_XOR		7'h40
`define FN_SLL		7'h39
`define FN_SRL		7'h34
`define FN_MULQ		7'h20

`endif

// File: hw/fu_pkg.sv
`include "fu_consts.svh"

package fu_pkg;

	typedef struct packed {
		logic [5:0]	opcode;
		logic [4:0]	ra;
		logic [7:0]	lit;	// rb sits in lit[7:3] when lit_flag is clear.
		logic		lit_flag;
		logic [6:0]	func;
		logic [4:0]	rc;
	} op_fmt_t;

	typedef struct packed {
		logic [5:0]		opcode;
		logic [4:0]		ra;
		logic [20:0]	disp;	// word displacement.
	} br_fmt_t;

	typedef union packed {
		op_fmt_t	op;
		br_fmt_t	br;
	} alpha_inst_u;

	typedef enum logic [2:0] {
		SEL_NONE		= 3'd0,
		SEL_ALU			= 3'd1,
		SEL_COND_BR		= 3'd2,
		SEL_UNCOND_BR	= 3'd3,
		SEL_MULT		= 3'd4,
		SEL_LOAD		= 3'd5,
		SEL_STORE		= 3'd6
	} fu_sel_e;

	typedef struct packed {
		logic					vld;
		logic [63:0]			npc;
		logic [`ROB_IDX_W-1:0]	rob_idx;
		logic [63:0]			ra_value;
		logic [63:0]			rb_value;
		logic [`PRF_IDX_W-1:0]	dest_tag;
		alpha_inst_u			inst;
		fu_sel_e				sel;
	} issue_t;

	typedef struct packed {
		logic					start;
		logic [63:0]			opa;
		logic [63:0]			opb;	// literal already resolved.
		alpha_inst_u			inst;
		logic [`PRF_IDX_W-1:0]	dest_tag;
		logic [`ROB_IDX_W-1:0]	rob_idx;
	} alu_req_t;

	typedef alu_req_t mult_req_t;

	typedef struct packed {
		logic					start;
		logic [63:0]			npc;
		logic [63:0]			ra_value;
		logic [63:0]			disp;	// byte offset.
		logic [5:0]				opcode;
		logic [`ROB_IDX_W-1:0]	rob_idx;
	} br_req_t;

	typedef struct packed {
		logic					done;
		logic [63:0]			value;
		logic [`PRF_IDX_W-1:0]	dest_tag;
		logic [`ROB_IDX_W-1:0]	rob_idx;
	} unit_result_t;

	typedef struct packed {
		logic					done;
		logic					taken;
		logic [63:0]			target;
		logic [`ROB_IDX_W-1:0]	rob_idx;
	} br_result_t;

	typedef struct packed {
		logic					done;
		logic [`ROB_IDX_W-1:0]	idx;
		logic					br_taken;
		logic [63:0]			br_target;
	} rob_done_t;

	typedef struct packed {
		logic					vld;
		logic [`PRF_IDX_W-1:0]	tag;
		logic [63:0]			value;
	} cdb_t;

endpackage

// File: hw/fu_issue_decode.sv
`timescale 1ns/1ps

module fu_issue_decode (
	input	fu_pkg::issue_t		issue_i,
	output	fu_pkg::alu_req_t	alu_req_o,
	output	fu_pkg::br_req_t	br_req_o,
	output	fu_pkg::mult_req_t	mult_req_o
);

	logic			alu_sel;
	logic			br_sel;
	logic			mult_sel;
	logic [63:0]	opb;
	logic [63:0]	disp;

	always_comb begin
		alu_sel = 1'b0;
		br_sel = 1'b0;
		mult_sel = 1'b0;
		if (issue_i.vld) begin
			case (issue_i.sel)
				fu_pkg::SEL_ALU:		alu_sel = 1'b1;
				fu_pkg::SEL_COND_BR,
				fu_pkg::SEL_UNCOND_BR:	br_sel = 1'b1;
				fu_pkg::SEL_MULT:		mult_sel = 1'b1;
				default:				;	// memory ops have no unit here.
			endcase
		end
	end

	assign opb = issue_i.inst.op.lit_flag ? {56'd0, issue_i.inst.op.lit} : issue_i.rb_value;
	assign disp = {{41{issue_i.inst.br.disp[20]}}, issue_i.inst.br.disp, 2'b00};

	assign alu_req_o = '{start: alu_sel, opa: issue_i.ra_value, opb: opb, inst: issue_i.inst,
		dest_tag: issue_i.dest_tag, rob_idx: issue_i.rob_idx};

	assign mult_req_o = '{start: mult_sel, opa: issue_i.ra_value, opb: opb, inst: issue_i.inst,
		dest_tag: issue_i.dest_tag, rob_idx: issue_i.rob_idx};

	assign br_req_o = '{start: br_sel, npc: issue_i.npc, ra_value: issue_i.ra_value,
		disp: disp, opcode: issue_i.inst.br.opcode, rob_idx: issue_i.rob_idx};

endmodule

// File: hw/int_alu.sv
`timescale 1ns/1ps
`include "fu_consts.svh"

module int_alu (
	input	logic					clk,
	input	logic					rst,
	input	fu_pkg::alu_req_t		req_i,
	output	fu_pkg::unit_result_t	res_o
);

	logic [63:0]			result;
	logic					done_r;
	logic [63:0]			value_r;
	logic [`PRF_IDX_W-1:0]	tag_r;
	logic [`ROB_IDX_W-1:0]	idx_r;

	always_comb begin
		result = 64'd0;
		case (req_i.inst.op.opcode)
			`OP_INTA: begin
				case (req_i.inst.op.func)
					`FN_ADDQ:	result = req_i.opa + req_i.opb;
					`FN_SUBQ:	result = req_i.opa - req_i.opb;
					`FN_CMPEQ:	result = {63'd0, req_i.opa == req_i.opb};
					`FN_CMPULT:	result = {63'd0, req_i.opa < req_i.opb};	// unsigned.
					default:	result = 64'd0;
				endcase
			end
			`OP_INTL: begin
				case (req_i.inst.op.func)
					`FN_AND:	result = req_i.opa & req_i.opb;
					`FN_BIS:	result = req_i.opa | req_i.opb;
					`FN_XOR:	result = req_i.opa ^ req_i.opb;
					default:	result = 64'd0;
				endcase
			end
			`OP_INTS: begin
				case (req_i.inst.op.func)
					`FN_SLL:	result = req_i.opa << req_i.opb[5:0];
					`FN_SRL:	result = req_i.opa >> req_i.opb[5:0];
					default:	result = 64'd0;
				endcase
			end
			default: result = 64'd0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done_r <= 1'b0;
		end else begin
			done_r <= req_i.start;
		end
	end

	always_ff @(posedge clk) begin
		if (req_i.start) begin
			value_r <= result;
			tag_r <= req_i.dest_tag;
			idx_r <= req_i.rob_idx;
		end
	end

	assign res_o = '{done: done_r, value: value_r, dest_tag: tag_r, rob_idx: idx_r};

endmodule

// File: hw/br_alu.sv
`timescale 1ns/1ps
`include "fu_consts.svh"

module br_alu (
	input	logic				clk,
	input	logic				rst,
	input	fu_pkg::br_req_t	req_i,
	output	fu_pkg::br_result_t	res_o
);

	logic					taken;
	logic [63:0]			target;
	logic					done_r;
	logic					taken_r;
	logic [63:0]			target_r;
	logic [`ROB_IDX_W-1:0]	idx_r;

	assign target = req_i.npc + req_i.disp;

	always_comb begin
		case (req_i.opcode)
			`OP_BR:		taken = 1'b1;
			`OP_BEQ:	taken = (req_i.ra_value == 64'd0);
			`OP_BNE:	taken = (req_i.ra_value != 64'd0);
			`OP_BLT:	taken = $signed(req_i.ra_value) < 0;
			`OP_BGE:	taken = $signed(req_i.ra_value) >= 0;
			default:	taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done_r <= 1'b0;
		end else begin
			done_r <= req_i.start;
		end
	end

	always_ff @(posedge clk) begin
		if (req_i.start) begin
			taken_r <= taken;
			target_r <= target;
			idx_r <= req_i.rob_idx;
		end
	end

	assign res_o = '{done: done_r, taken: taken_r, target: target_r, rob_idx: idx_r};

endmodule

// File: hw/mult.sv
`timescale 1ns/1ps
`include "fu_consts.svh"

module mult (
	input	logic					clk,
	input	logic					rst,
	input	fu_pkg::mult_req_t		req_i,
	output	fu_pkg::unit_result_t	res_o
);

	localparam int SLICE_W = 64 / `MULT_STAGES;

	logic [`MULT_STAGES-1:0]	vld_r;
	logic [63:0]				sum_r [`MULT_STAGES];
	logic [`PRF_IDX_W-1:0]		tag_r [`MULT_STAGES];
	logic [`ROB_IDX_W-1:0]		idx_r [`MULT_STAGES];
	logic [63:0]				opa_r [`MULT_STAGES-1];
	logic [63:0]				opb_r [`MULT_STAGES-1];

	// one slice of opb times opa, moved to its weight.
	function automatic logic [63:0] partial(input logic [63:0] a, input logic [63:0] b,
			input int k);
		logic [SLICE_W-1:0] s;
		s = b[k*SLICE_W +: SLICE_W];
		return (a * 64'(s)) << (k * SLICE_W);
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r <= '0;
		end else begin
			vld_r <= {vld_r[`MULT_STAGES-2:0], req_i.start};
		end
	end

	always_ff @(posedge clk) begin
		sum_r[0] <= partial(req_i.opa, req_i.opb, 0);
		tag_r[0] <= req_i.dest_tag;
		idx_r[0] <= req_i.rob_idx;
		opa_r[0] <= req_i.opa;
		opb_r[0] <= req_i.opb;
		for (int k = 1; k < `MULT_STAGES; k++) begin
			sum_r[k] <= sum_r[k-1] + partial(opa_r[k-1], opb_r[k-1], k);	// low 64 bits only.
			tag_r[k] <= tag_r[k-1];
			idx_r[k] <= idx_r[k-1];
		end
		for (int k = 1; k < `MULT_STAGES - 1; k++) begin
			opa_r[k] <= opa_r[k-1];
			opb_r[k] <= opb_r[k-1];
		end
	end

	assign res_o = '{done: vld_r[`MULT_STAGES-1], value: sum_r[`MULT_STAGES-1],
		dest_tag: tag_r[`MULT_STAGES-1], rob_idx: idx_r[`MULT_STAGES-1]};

	a_start_to_done: assert property (@(posedge clk) disable iff (rst)
		req_i.start |-> ##(`MULT_STAGES) (res_o.done
			&& res_o.dest_tag == $past(req_i.dest_tag, `MULT_STAGES)
			&& res_o.rob_idx == $past(req_i.rob_idx, `MULT_STAGES)))
		else $error("multiply start without its done after %0d cycles", `MULT_STAGES);

	// routing is by select code, so check that a MULQ word really came along.
	a_mulq_only: assert property (@(posedge clk) disable iff (rst)
		req_i.start |-> (req_i.inst.op.opcode == `OP_INTM && req_i.inst.op.func == `FN_MULQ))
		else $error("multiplier started on a non-MULQ instruction");

endmodule

// File: hw/fu_writeback.sv
`timescale 1ns/1ps
`include "fu_consts.svh"

module fu_writeback (
	input	logic					clk,
	input	logic					rst,
	input	fu_pkg::unit_result_t	alu_i,
	input	fu_pkg::unit_result_t	mult_i,
	input	fu_pkg::br_result_t		br_i,
	output	fu_pkg::rob_done_t		rob_o,
	output	fu_pkg::cdb_t			cdb_o
);

	logic [`ROB_IDX_W-1:0]	rob_idx;
	fu_pkg::cdb_t			cdb_nxt;
	fu_pkg::cdb_t			cdb_r;

	assign rob_idx = br_i.done ? br_i.rob_idx :
		mult_i.done ? mult_i.rob_idx :
		alu_i.done ? alu_i.rob_idx : '0;

	assign rob_o = '{done: alu_i.done | mult_i.done | br_i.done, idx: rob_idx,
		br_taken: br_i.done & br_i.taken, br_target: br_i.done ? br_i.target : 64'd0};

	always_comb begin
		if (alu_i.done) begin
			cdb_nxt = '{vld: 1'b1, tag: alu_i.dest_tag, value: alu_i.value};
		end else if (mult_i.done) begin
			cdb_nxt = '{vld: 1'b1, tag: mult_i.dest_tag, value: mult_i.value};
		end else begin
			cdb_nxt = '{vld: 1'b0, tag: `ZERO_REG, value: 64'd0};	// idle bus.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cdb_r <= '{vld: 1'b0, tag: `ZERO_REG, value: 64'd0};
		end else begin
			cdb_r <= cdb_nxt;
		end
	end

	assign cdb_o = cdb_r;	// also the register file write port.

	a_one_done: assert property (@(posedge clk) disable iff (rst)
		$onehot0({alu_i.done, mult_i.done, br_i.done}))
		else $error("two units completed in the same cycle");

endmodule

// File: hw/fu_main.sv
`timescale 1ns/1ps

module fu_main (
	input	logic				clk,
	input	logic				rst,
	input	fu_pkg::issue_t		issue_i,
	output	fu_pkg::rob_done_t	rob_o,
	output	fu_pkg::cdb_t		cdb_o
);

	fu_pkg::alu_req_t		alu_req;
	fu_pkg::br_req_t		br_req;
	fu_pkg::mult_req_t		mult_req;
	fu_pkg::unit_result_t	alu_res;
	fu_pkg::unit_result_t	mult_res;
	fu_pkg::br_result_t		br_res;

	fu_issue_decode fu_issue_decode_i (
		.issue_i	(issue_i),
		.alu_req_o	(alu_req),
		.br_req_o	(br_req),
		.mult_req_o	(mult_req)
	);

	int_alu int_alu_i (
		.clk	(clk),
		.rst	(rst),
		.req_i	(alu_req),
		.res_o	(alu_res)
	);

	br_alu br_alu_i (
		.clk	(clk),
		.rst	(rst),
		.req_i	(br_req),
		.res_o	(br_res)
	);

	mult mult_i (
		.clk	(clk),
		.rst	(rst),
		.req_i	(mult_req),
		.res_o	(mult_res)
	);

	fu_writeback fu_writeback_i (
		.clk	(clk),
		.rst	(rst),
		.alu_i	(alu_res),
		.mult_i	(mult_res),
		.br_i	(br_res),
		.rob_o	(rob_o),
		.cdb_o	(cdb_o)
	);

endmodule

// File: dv/fu_main_tb.sv
`timescale 1ns/1ps
`include "fu_consts.svh"

module fu_main_tb;

	localparam logic [5:0] ALU_OPC [9] = '{`OP_INTA, `OP_INTA, `OP_INTA, `OP_INTA, `OP_INTL,
		`OP_INTL, `OP_INTL, `OP_INTS, `OP_INTS};
	localparam logic [6:0] ALU_FN [9] = '{`FN_ADDQ, `FN_SUBQ, `FN_CMPEQ, `FN_CMPULT, `FN_AND,
		`FN_BIS, `FN_XOR, `FN_SLL, `FN_SRL};
	localparam logic [5:0] BR_OPC [5] = '{`OP_BR, `OP_BEQ, `OP_BNE, `OP_BLT, `OP_BGE};

	logic				clk;
	logic				rst;
	fu_pkg::issue_t		issue;
	fu_pkg::rob_done_t	rob;
	fu_pkg::cdb_t		cdb;
	fu_pkg::rob_done_t	rob_idle;
	fu_pkg::cdb_t		cdb_idle;
	integer				seed;

	fu_main fu_main_i (.clk(clk), .rst(rst), .issue_i(issue), .rob_o(rob), .cdb_o(cdb));

	always #10 clk = ~clk;

	function automatic logic [63:0] rand64();
		return {32'($random(seed)), 32'($random(seed))};
	endfunction

	task automatic stop_on_error();
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_wrong_value(input string name, input logic [63:0] exp_v,
			input logic [63:0] got_v);
		$display("MISMATCH time=%0t %s expected=%0h got=%0h", $time, name, exp_v, got_v);
		stop_on_error();
	endtask

	task automatic check_rob(input fu_pkg::rob_done_t exp, input fu_pkg::rob_done_t got);
		if (got.done !== exp.done)
			report_wrong_value("rob_o.done", 64'(exp.done), 64'(got.done));
		if (got.idx !== exp.idx)
			report_wrong_value("rob_o.idx", 64'(exp.idx), 64'(got.idx));
		if (got.br_taken !== exp.br_taken)
			report_wrong_value("rob_o.br_taken", 64'(exp.br_taken), 64'(got.br_taken));
		if (got.br_target !== exp.br_target)
			report_wrong_value("rob_o.br_target", exp.br_target, got.br_target);
	endtask

	task automatic check_cdb(input fu_pkg::cdb_t exp, input fu_pkg::cdb_t got);
		if (got.vld !== exp.vld)
			report_wrong_value("cdb_o.vld", 64'(exp.vld), 64'(got.vld));
		if (got.tag !== exp.tag)
			report_wrong_value("cdb_o.tag", 64'(exp.tag), 64'(got.tag));
		if (got.value !== exp.value)
			report_wrong_value("cdb_o.value", exp.value, got.value);
	endtask

	task automatic check_latency(input string what, input int exp_c, input int got_c);
		if (got_c != exp_c)
			report_wrong_value(what, 64'(exp_c), 64'(got_c));
	endtask

	task automatic align_to_drive();
		@(posedge clk);
		#2;
	endtask

	// call 2 ns after a rising edge and it returns 2 ns after the edge that took the issue.
	task automatic drive_issue(input logic vld, input fu_pkg::fu_sel_e sel,
			input fu_pkg::alpha_inst_u inst, input logic [63:0] ra, input logic [63:0] rb,
			input logic [`PRF_IDX_W-1:0] tag, input logic [`ROB_IDX_W-1:0] idx,
			input logic [63:0] npc);
		issue = '{vld: vld, npc: npc, rob_idx: idx, ra_value: ra, rb_value: rb, dest_tag: tag,
			inst: inst, sel: sel};
		@(posedge clk);
		#2;
		issue.vld = 1'b0;
	endtask

	task automatic wait_rob(input string what, input int limit, output int cycles);
		@(negedge clk);
		cycles = 1;
		while (rob.done !== 1'b1) begin
			if (cycles >= limit) begin
				$display("timeout: no ROB done within %0d cycles while waiting for %s",
					limit, what);
				stop_on_error();
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic test_alu_ops();
		fu_pkg::alpha_inst_u	inst;
		fu_pkg::rob_done_t		exp_rob;
		fu_pkg::cdb_t			exp_cdb;
		logic [63:0]			a;
		logic [63:0]			b;
		logic [63:0]			opb;
		logic [63:0]			res;
		int						r;
		int						cycles;
		for (int k = 0; k < 9; k++) begin
			for (int lit = 0; lit < 2; lit++) begin
				align_to_drive();
				a = rand64();
				b = (k == 2 && lit == 0) ? a : rand64();	// one equal pair for cmpeq.
				r = $random(seed);
				inst = '0;
				inst.op.opcode = ALU_OPC[k];
				inst.op.func = ALU_FN[k];
				inst.op.lit_flag = lit[0];
				inst.op.lit = r[7:0];
				opb = lit[0] ? {56'd0, r[7:0]} : b;
				case (k)
					0: res = a + opb;
					1: res = a - opb;
					2: res = (a == opb) ? 64'd1 : 64'd0;
					3: res = (a < opb) ? 64'd1 : 64'd0;
					4: res = a & opb;
					5: res = a | opb;
					6: res = a ^ opb;
					7: res = a << opb[5:0];
					default: res = a >> opb[5:0];
				endcase
				exp_rob = '{done: 1'b1, idx: r[12:8], br_taken: 1'b0, br_target: 64'd0};
				exp_cdb = '{vld: 1'b1, tag: r[18:13], value: res};
				drive_issue(1'b1, fu_pkg::SEL_ALU, inst, a, b, r[18:13], r[12:8], rand64());
				wait_rob("ALU done", 5, cycles);
				check_latency("ALU done latency", 1, cycles);
				check_rob(exp_rob, rob);
				@(negedge clk);
				check_cdb(exp_cdb, cdb);
			end
		end
	endtask

	task automatic test_branches();
		fu_pkg::alpha_inst_u	inst;
		fu_pkg::rob_done_t		exp_rob;
		fu_pkg::fu_sel_e		sel;
		logic [63:0]			ra;
		logic [63:0]			npc;
		logic signed [20:0]		disp;
		logic signed [63:0]		offset;
		int						r;
		int						cycles;
		for (int k = 0; k < 5; k++) begin
			for (int j = 0; j < 3; j++) begin
				align_to_drive();
				ra = rand64();
				case (j)
					0: ra[63] = 1'b1;
					1: ra = 64'd0;
					default: ra = {1'b0, ra[62:1], 1'b1};	// positive.
				endcase
				r = $random(seed);
				npc = rand64();
				disp = r[20:0];
				offset = disp;
				inst = '0;
				inst.br.opcode = BR_OPC[k];
				inst.br.disp = disp;
				exp_rob.done = 1'b1;
				exp_rob.idx = r[25:21];
				exp_rob.br_target = npc + offset * 4;
				case (k)
					0: exp_rob.br_taken = 1'b1;
					1: exp_rob.br_taken = (j == 1);
					2: exp_rob.br_taken = (j != 1);
					3: exp_rob.br_taken = (j == 0);
					default: exp_rob.br_taken = (j != 0);
				endcase
				if (k == 0)
					sel = fu_pkg::SEL_UNCOND_BR;
				else
					sel = fu_pkg::SEL_COND_BR;
				drive_issue(1'b1, sel, inst, ra, rand64(), r[31:26], r[25:21], npc);
				wait_rob("branch done", 5, cycles);
				check_latency("branch done latency", 1, cycles);
				check_rob(exp_rob, rob);
				@(negedge clk);
				check_cdb(cdb_idle, cdb);
			end
		end
	endtask

	task automatic test_mult_back_to_back();
		fu_pkg::alpha_inst_u	inst;
		fu_pkg::rob_done_t		exp_rob [4];
		fu_pkg::cdb_t			exp_cdb [4];
		logic [63:0]			a;
		logic [63:0]			b;
		int						cycles;
		inst = '0;
		inst.op.opcode = `OP_INTM;
		inst.op.func = `FN_MULQ;
		align_to_drive();
		for (int i = 0; i < 4; i++) begin
			a = rand64();
			b = rand64();
			exp_rob[i] = '{done: 1'b1, idx: 5'(i + 3), br_taken: 1'b0, br_target: 64'd0};
			exp_cdb[i] = '{vld: 1'b1, tag: 6'(i + 20), value: a * b};	// low half only.
			drive_issue(1'b1, fu_pkg::SEL_MULT, inst, a, b, exp_cdb[i].tag, exp_rob[i].idx,
				64'd0);
		end
		wait_rob("multiply done", 10, cycles);
		check_latency("multiply done latency", `MULT_STAGES - 3, cycles);
		for (int i = 0; i <= 4; i++) begin
			if (i > 0)
				@(negedge clk);
			check_rob((i < 4) ? exp_rob[i] : rob_idle, rob);
			if (i > 0)
				check_cdb(exp_cdb[i - 1], cdb);
		end
	endtask

	task automatic test_no_unit();
		fu_pkg::alpha_inst_u	inst;
		fu_pkg::fu_sel_e		sels [4];
		sels = '{fu_pkg::SEL_NONE, fu_pkg::SEL_LOAD, fu_pkg::SEL_STORE, fu_pkg::SEL_ALU};
		inst = '0;
		inst.op.opcode = `OP_INTA;
		inst.op.func = `FN_ADDQ;
		// the last one is an ALU issue with vld low.
		for (int s = 0; s < 4; s++) begin
			align_to_drive();
			drive_issue(s != 3, sels[s], inst, rand64(), rand64(), 6'd5, 5'd7, rand64());
			repeat (10) begin
				@(negedge clk);
				check_rob(rob_idle, rob);
				check_cdb(cdb_idle, cdb);
			end
		end
	endtask

	initial begin
		seed = 56;
		clk = 1'b0;
		rst = 1'b1;
		issue = '0;
		rob_idle = '{done: 1'b0, idx: '0, br_taken: 1'b0, br_target: 64'd0};
		cdb_idle = '{vld: 1'b0, tag: `ZERO_REG, value: 64'd0};
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		@(negedge clk);
		check_rob(rob_idle, rob);
		check_cdb(cdb_idle, cdb);
		test_alu_ops();
		test_branches();
		test_mult_back_to_back();
		test_no_unit();
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hw
hw/fu_pkg.sv
hw/fu_issue_decode.sv
hw/int_alu.sv
hw/br_alu.sv
hw/mult.sv
hw/fu_writeback.sv
hw/fu_main.sv
dv/fu_main_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the execution stage testbench with Verilator and runs it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -f filelist.f --top-module fu_main_tb \
	--Mdir "$OBJ" -o fu_main_tb; then
	echo "build failed"
	exit 1
fi

"./$OBJ/fu_main_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1
